// ==== common/cpu_config.svh ====
// --------------------------------------------------
// reset vector, register count, opcode and funct
// codes of the integer subset, full-word strobe
// --------------------------------------------------
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// boot rom vector, first fetch address
`define CPU_RESET_PC    32'hbfc00000
`define CPU_NUM_REGS    32

// primary opcodes
`define CPU_OP_SPECIAL  6'h00
`define CPU_OP_ADDIU    6'h09
`define CPU_OP_ORI      6'h0d
`define CPU_OP_LUI      6'h0f
`define CPU_OP_LW       6'h23
`define CPU_OP_SW       6'h2b

// funct codes under SPECIAL
`define CPU_FN_ADDU     6'h21
`define CPU_FN_SUBU     6'h23
`define CPU_FN_AND      6'h24
`define CPU_FN_OR       6'h25
`define CPU_FN_XOR      6'h26
`define CPU_FN_SLT      6'h2a
`define CPU_FN_SLTU     6'h2b

// word store, all four lanes
`define CPU_SW_STROBE   4'hf

`endif

// ==== common/cpu_pkg.sv ====
// --------------------------------------------------
// shared types: words, register numbers, byte
// enables, ALU operations and bypass sources
// --------------------------------------------------
package cpu_pkg;

    // data and address word
    typedef logic [31:0] word_t;

    // register number, rs/rt/rd field
    typedef logic [4:0] reg_addr_t;

    // one bit per byte lane
    typedef logic [3:0] byte_en_t;

    // ALU operations
    // pass_b only serves LUI, operand b is already shifted
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_pass_b
    } alu_op_e;

    // where a decode operand comes from
    typedef enum logic [1:0] {
        from_rf,
        from_mem,
        from_wb
    } fwd_sel_e;

endpackage

// ==== common/cpu_if.sv ====
// --------------------------------------------------
// hazard_if, id_ex_if, ex_mem_if
// --------------------------------------------------
`timescale 1ns/100ps

// decode sources out, bypass selects and stall back
interface hazard_if;
    cpu_pkg::reg_addr_t rs;
    cpu_pkg::reg_addr_t rt;
    logic               rs_used;
    logic               rt_used;
    cpu_pkg::fwd_sel_e  fwd_a;
    cpu_pkg::fwd_sel_e  fwd_b;
    logic               stall;

    modport decode (output rs, rt, rs_used, rt_used, input fwd_a, fwd_b, stall);
    modport ctrl (input rs, rt, rs_used, rt_used, output fwd_a, fwd_b, stall);
endinterface

// execute-bound register contents
interface id_ex_if;
    logic               valid;
    cpu_pkg::word_t     pc;
    cpu_pkg::alu_op_e   alu_op;
    cpu_pkg::word_t     op_a;
    cpu_pkg::word_t     op_b;
    cpu_pkg::word_t     store_data;
    cpu_pkg::reg_addr_t dest;
    logic               wen;
    logic               mem_read;
    logic               mem_write;

    modport decode (output valid, pc, alu_op, op_a, op_b, store_data, dest, wen,
                    mem_read, mem_write);
    modport exec (input valid, pc, alu_op, op_a, op_b, store_data, dest, wen,
                  mem_read, mem_write);
    // hazard unit only looks at the destination
    modport ctrl (input valid, dest, wen);
endinterface

// memory-stage register contents
interface ex_mem_if;
    logic               valid;
    cpu_pkg::word_t     pc;
    cpu_pkg::word_t     result;
    cpu_pkg::reg_addr_t dest;
    logic               wen;
    logic               mem_read;

    modport exec (output valid, pc, result, dest, wen, mem_read);
    modport mem (input valid, pc, result, dest, wen, mem_read);
    modport ctrl (input valid, dest, wen, mem_read);
endinterface

// ==== hdl/fetch_stage.sv ====
// --------------------------------------------------
// PC register, next-fetch address, fetch valid
// --------------------------------------------------
`timescale 1ns/100ps
`include "cpu_config.svh"

module fetch_stage (
    input  logic           clk,
    input  logic           resetn,
    input  logic           stall,
    output cpu_pkg::word_t fetch_addr,
    output cpu_pkg::word_t pc,
    output logic           valid
);

    // pc names the word the SRAM returns this cycle
    // first cycle out of reset re-issues the reset vector
    // stall re-reads the same word so the IF/ID hold stays coherent
    always_comb begin
        if (stall || !valid) begin
            fetch_addr = pc;
        end else begin
            fetch_addr = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc    <= `CPU_RESET_PC;
            valid <= 1'b0;
        end else begin
            pc    <= fetch_addr;
            // one idle cycle while the first read is in flight
            valid <= 1'b1;
        end
    end

endmodule

// ==== decode/reg_file.sv ====
// --------------------------------------------------
// 32x32 register file, 2 read / 1 write, $0 = 0
// --------------------------------------------------
`timescale 1ns/100ps
`include "cpu_config.svh"

module reg_file (
    input  logic               clk,
    input  cpu_pkg::reg_addr_t raddr_a,
    input  cpu_pkg::reg_addr_t raddr_b,
    output cpu_pkg::word_t     rdata_a,
    output cpu_pkg::word_t     rdata_b,
    input  logic               wen,
    input  cpu_pkg::reg_addr_t waddr,
    input  cpu_pkg::word_t     wdata
);

    cpu_pkg::word_t regs [`CPU_NUM_REGS];

    // write lands at the end of the writeback cycle
    // same-cycle readers take the bypass instead
    always_ff @(posedge clk) begin
        if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    // async reads, entry 0 never looked at
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

// ==== decode/decode_stage.sv ====
// --------------------------------------------------
// IF/ID register, instruction decode, immediates,
// bypass muxes and the execute-bound register
// --------------------------------------------------
`timescale 1ns/100ps
`include "cpu_config.svh"

module decode_stage (
    input  logic               clk,
    input  logic               resetn,
    input  cpu_pkg::word_t     f_pc,
    input  logic               f_valid,
    input  cpu_pkg::word_t     inst,
    output cpu_pkg::reg_addr_t rf_raddr_a,
    output cpu_pkg::reg_addr_t rf_raddr_b,
    input  cpu_pkg::word_t     rf_rdata_a,
    input  cpu_pkg::word_t     rf_rdata_b,
    input  cpu_pkg::word_t     m_result,
    input  cpu_pkg::word_t     w_wdata,
    hazard_if.decode           hz,
    id_ex_if.decode            ide
);

    // IF/ID register
    logic           d_valid;
    cpu_pkg::word_t d_pc;
    cpu_pkg::word_t d_inst;

    // decoded fields
    cpu_pkg::reg_addr_t rs;
    cpu_pkg::reg_addr_t rt;
    cpu_pkg::alu_op_e   alu_op;
    cpu_pkg::word_t     imm;
    cpu_pkg::reg_addr_t dest;
    cpu_pkg::word_t     rt_val;
    logic               use_imm;
    logic               rs_rd;
    logic               rt_rd;
    logic               wen;
    logic               mem_read;
    logic               mem_write;

    // bypass source per operand
    function automatic cpu_pkg::word_t pick(input cpu_pkg::fwd_sel_e sel,
                                            input cpu_pkg::word_t rf);
        case (sel)
            cpu_pkg::from_mem: pick = m_result;
            cpu_pkg::from_wb:  pick = w_wdata;
            default:           pick = rf;
        endcase
    endfunction

    // --------------------------------------------------
    // IF/ID, frozen while stalled
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            d_valid <= 1'b0;
        end else if (!hz.stall) begin
            d_valid <= f_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hz.stall) begin
            d_pc   <= f_pc;
            d_inst <= inst;
        end
    end

    // --------------------------------------------------
    // decode
    // --------------------------------------------------
    assign rs = d_inst[25:21];
    assign rt = d_inst[20:16];

    always_comb begin
        // defaults give a non-writing slot
        alu_op    = cpu_pkg::alu_add;
        imm       = {{16{d_inst[15]}}, d_inst[15:0]};
        use_imm   = 1'b1;
        rs_rd     = 1'b1;
        rt_rd     = 1'b0;
        dest      = rt;
        wen       = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        case (d_inst[31:26])
            `CPU_OP_SPECIAL: begin
                use_imm = 1'b0;
                rt_rd   = 1'b1;
                dest    = d_inst[15:11];
                wen     = 1'b1;
                case (d_inst[5:0])
                    `CPU_FN_ADDU: alu_op = cpu_pkg::alu_add;
                    `CPU_FN_SUBU: alu_op = cpu_pkg::alu_sub;
                    `CPU_FN_AND:  alu_op = cpu_pkg::alu_and;
                    `CPU_FN_OR:   alu_op = cpu_pkg::alu_or;
                    `CPU_FN_XOR:  alu_op = cpu_pkg::alu_xor;
                    `CPU_FN_SLT:  alu_op = cpu_pkg::alu_slt;
                    `CPU_FN_SLTU: alu_op = cpu_pkg::alu_sltu;
                    // shifts and the rest, nop included
                    default:      wen    = 1'b0;
                endcase
            end
            `CPU_OP_ADDIU: wen = 1'b1;
            `CPU_OP_ORI: begin
                alu_op = cpu_pkg::alu_or;
                imm    = {16'h0000, d_inst[15:0]};
                wen    = 1'b1;
            end
            `CPU_OP_LUI: begin
                alu_op = cpu_pkg::alu_pass_b;
                imm    = {d_inst[15:0], 16'h0000};
                rs_rd  = 1'b0;
                wen    = 1'b1;
            end
            `CPU_OP_LW: begin
                wen      = 1'b1;
                mem_read = 1'b1;
            end
            `CPU_OP_SW: begin
                // base plus offset, rt is the store word
                rt_rd     = 1'b1;
                mem_write = 1'b1;
            end
            default: rs_rd = 1'b0;
        endcase
        // $0 target never writes, later stages need no zero check
        if (dest == '0) begin
            wen = 1'b0;
        end
    end

    // register reads and hazard request
    assign rf_raddr_a = rs;
    assign rf_raddr_b = rt;
    assign hz.rs      = rs;
    assign hz.rt      = rt;
    assign hz.rs_used = d_valid & rs_rd;
    assign hz.rt_used = d_valid & rt_rd;

    assign rt_val = pick(hz.fwd_b, rf_rdata_b);

    // --------------------------------------------------
    // execute-bound register, bubble on stall
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ide.valid <= 1'b0;
        end else begin
            ide.valid <= d_valid & ~hz.stall;
        end
    end

    always_ff @(posedge clk) begin
        ide.pc         <= d_pc;
        ide.alu_op     <= alu_op;
        ide.op_a       <= pick(hz.fwd_a, rf_rdata_a);
        ide.op_b       <= use_imm ? imm : rt_val;
        ide.store_data <= rt_val;
        ide.dest       <= dest;
        ide.wen        <= wen;
        ide.mem_read   <= mem_read;
        ide.mem_write  <= mem_write;
    end

endmodule

// ==== hdl/exec_stage.sv ====
// --------------------------------------------------
// ALU, data SRAM request, EX/MEM register
// --------------------------------------------------
`timescale 1ns/100ps
`include "cpu_config.svh"

module exec_stage (
    input  logic              clk,
    input  logic              resetn,
    id_ex_if.exec             ide,
    ex_mem_if.exec            exm,
    output cpu_pkg::byte_en_t data_sram_wen,
    output cpu_pkg::word_t    data_sram_addr,
    output cpu_pkg::word_t    data_sram_wdata
);

    cpu_pkg::word_t sum;
    cpu_pkg::word_t result;

    // shared adder, also the load/store address
    assign sum = ide.op_a + ide.op_b;

    // wrapping arithmetic, no overflow trap
    always_comb begin
        case (ide.alu_op)
            cpu_pkg::alu_sub:  result = ide.op_a - ide.op_b;
            cpu_pkg::alu_and:  result = ide.op_a & ide.op_b;
            cpu_pkg::alu_or:   result = ide.op_a | ide.op_b;
            cpu_pkg::alu_xor:  result = ide.op_a ^ ide.op_b;
            cpu_pkg::alu_slt:  result = {31'd0, $signed(ide.op_a) < $signed(ide.op_b)};
            cpu_pkg::alu_sltu: result = {31'd0, ide.op_a < ide.op_b};
            cpu_pkg::alu_pass_b: result = ide.op_b;
            default:           result = sum;
        endcase
    end

    // request goes out this cycle, load data returns next cycle
    assign data_sram_addr  = sum;
    assign data_sram_wdata = ide.store_data;
    assign data_sram_wen   = (ide.valid && ide.mem_write) ? `CPU_SW_STROBE : '0;

    // --------------------------------------------------
    // EX/MEM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            exm.valid <= 1'b0;
        end else begin
            exm.valid <= ide.valid;
        end
    end

    always_ff @(posedge clk) begin
        exm.pc       <= ide.pc;
        exm.result   <= result;
        exm.dest     <= ide.dest;
        exm.wen      <= ide.wen;
        exm.mem_read <= ide.mem_read;
    end

endmodule

// ==== hdl/mem_stage.sv ====
// --------------------------------------------------
// load select, MEM/WB register, regfile write
// and debug writeback port
// --------------------------------------------------
`timescale 1ns/100ps

module mem_stage (
    input  logic               clk,
    input  logic               resetn,
    ex_mem_if.mem              exm,
    input  cpu_pkg::word_t     data_sram_rdata,
    output cpu_pkg::word_t     m_result,
    output logic               w_wen,
    output cpu_pkg::reg_addr_t w_dest,
    output cpu_pkg::word_t     w_wdata,
    output cpu_pkg::word_t     debug_wb_pc,
    output cpu_pkg::byte_en_t  debug_wb_rf_wen,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum,
    output cpu_pkg::word_t     debug_wb_rf_wdata
);

    logic           wb_valid;
    logic           wb_wen;
    cpu_pkg::word_t wb_pc;

    // only ALU results bypass from here, loads stall in decode
    assign m_result = exm.result;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= exm.valid;
        end
    end

    // full words only, no lane shuffling
    always_ff @(posedge clk) begin
        wb_pc   <= exm.pc;
        wb_wen  <= exm.wen;
        w_dest  <= exm.dest;
        w_wdata <= exm.mem_read ? data_sram_rdata : exm.result;
    end

    // --------------------------------------------------
    // writeback
    // --------------------------------------------------
    assign w_wen = wb_valid & wb_wen;

    // debug mirrors the regfile write
    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wen   = {4{w_wen}};
    assign debug_wb_rf_wnum  = w_dest;
    assign debug_wb_rf_wdata = w_wdata;

endmodule

// ==== hdl/pipe_control.sv ====
// --------------------------------------------------
// hazard detection, bypass select, decode stall
// --------------------------------------------------
`timescale 1ns/100ps

module pipe_control (
    hazard_if.ctrl             hz,
    id_ex_if.ctrl              ide,
    ex_mem_if.ctrl             exm,
    input  logic               w_wen,
    input  cpu_pkg::reg_addr_t w_dest
);

    // {execute, memory, writeback} hits
    logic [2:0] hit_a;
    logic [2:0] hit_b;

    // wen already false for $0, so no zero test here
    function automatic logic [2:0] match(input cpu_pkg::reg_addr_t src, input logic used);
        match[2] = used & ide.valid & ide.wen & (ide.dest == src);
        match[1] = used & exm.valid & exm.wen & (exm.dest == src);
        match[0] = used & w_wen & (w_dest == src);
    endfunction

    // memory beats writeback when both hold the register
    function automatic cpu_pkg::fwd_sel_e sel(input logic [2:0] hit);
        if (hit[1]) begin
            sel = cpu_pkg::from_mem;
        end else if (hit[0]) begin
            sel = cpu_pkg::from_wb;
        end else begin
            sel = cpu_pkg::from_rf;
        end
    endfunction

    assign hit_a = match(hz.rs, hz.rs_used);
    assign hit_b = match(hz.rt, hz.rt_used);

    assign hz.fwd_a = sel(hit_a);
    assign hz.fwd_b = sel(hit_b);

    // result not ready in execute, load data not ready in memory
    assign hz.stall = hit_a[2] | (hit_a[1] & exm.mem_read)
                    | hit_b[2] | (hit_b[1] & exm.mem_read);

endmodule

// ==== hdl/mips_core.sv ====
// --------------------------------------------------
// five-stage MIPS32 core top, SRAM and debug ports
// --------------------------------------------------
`timescale 1ns/100ps

module mips_core (
    input  logic        clk,
    input  logic        resetn,

    output logic        inst_sram_en,
    output logic [3:0]  inst_sram_wen,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,

    output logic        data_sram_en,
    output logic [3:0]  data_sram_wen,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,

    // writeback trace
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_wen,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    cpu_pkg::word_t     f_pc;
    logic               f_valid;
    cpu_pkg::reg_addr_t rf_raddr_a;
    cpu_pkg::reg_addr_t rf_raddr_b;
    cpu_pkg::word_t     rf_rdata_a;
    cpu_pkg::word_t     rf_rdata_b;
    cpu_pkg::word_t     m_result;
    logic               w_wen;
    cpu_pkg::reg_addr_t w_dest;
    cpu_pkg::word_t     w_wdata;

    hazard_if hz ();
    id_ex_if  ide ();
    ex_mem_if exm ();

    // both SRAMs always enabled, instruction side read-only
    assign inst_sram_en    = 1'b1;
    assign inst_sram_wen   = 4'b0000;
    assign inst_sram_wdata = 32'd0;
    assign data_sram_en    = 1'b1;

    fetch_stage u_fetch (
        .clk        (clk),
        .resetn     (resetn),
        .stall      (hz.stall),
        .fetch_addr (inst_sram_addr),
        .pc         (f_pc),
        .valid      (f_valid)
    );

    decode_stage u_decode (
        .clk        (clk),
        .resetn     (resetn),
        .f_pc       (f_pc),
        .f_valid    (f_valid),
        .inst       (inst_sram_rdata),
        .rf_raddr_a (rf_raddr_a),
        .rf_raddr_b (rf_raddr_b),
        .rf_rdata_a (rf_rdata_a),
        .rf_rdata_b (rf_rdata_b),
        .m_result   (m_result),
        .w_wdata    (w_wdata),
        .hz         (hz.decode),
        .ide        (ide.decode)
    );

    reg_file u_rf (
        .clk     (clk),
        .raddr_a (rf_raddr_a),
        .raddr_b (rf_raddr_b),
        .rdata_a (rf_rdata_a),
        .rdata_b (rf_rdata_b),
        .wen     (w_wen),
        .waddr   (w_dest),
        .wdata   (w_wdata)
    );

    exec_stage u_exec (
        .clk             (clk),
        .resetn          (resetn),
        .ide             (ide.exec),
        .exm             (exm.exec),
        .data_sram_wen   (data_sram_wen),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata)
    );

    mem_stage u_mem (
        .clk               (clk),
        .resetn            (resetn),
        .exm               (exm.mem),
        .data_sram_rdata   (data_sram_rdata),
        .m_result          (m_result),
        .w_wen             (w_wen),
        .w_dest            (w_dest),
        .w_wdata           (w_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    pipe_control u_ctrl (
        .hz     (hz.ctrl),
        .ide    (ide.ctrl),
        .exm    (exm.ctrl),
        .w_wen  (w_wen),
        .w_dest (w_dest)
    );

endmodule

// ==== verification/mips_core_properties.sv ====
// --------------------------------------------------
// bound checks on the debug trace and data SRAM port
// --------------------------------------------------
`timescale 1ns/100ps
`include "cpu_config.svh"

module mips_core_properties (
    input logic        clk,
    input logic        resetn,
    input logic [3:0]  data_sram_wen,
    input logic [31:0] debug_wb_pc,
    input logic [3:0]  debug_wb_rf_wen
);

    // trace stays quiet while held in reset
    wb_quiet_in_reset: assert property (@(posedge clk) !resetn |-> debug_wb_rf_wen == 4'h0)
        else $error("debug writeback while in reset");

    // no store leaves the core during reset
    store_quiet_in_reset: assert property (@(posedge clk) !resetn |-> data_sram_wen == 4'h0)
        else $error("data SRAM write while in reset");

    // traced pc in the boot region, word aligned
    wb_pc_legal: assert property (@(posedge clk)
        (resetn && debug_wb_rf_wen != 4'h0)
        |-> (debug_wb_pc >= `CPU_RESET_PC && debug_wb_pc[1:0] == 2'b00))
        else $error("debug writeback pc out of range or unaligned");

endmodule

// ==== verification/tb_mips_core.sv ====
// --------------------------------------------------
// testbench for mips_core: clock, reset, SRAM models,
// program table with expected writebacks, checker
// --------------------------------------------------
`timescale 1ns/100ps
`include "cpu_config.svh"

module tb_mips_core;

    // cycles allowed between two writebacks
    localparam int WB_TIMEOUT = 50;

    logic        clk;
    logic        resetn;
    logic        inst_sram_en;
    logic [3:0]  inst_sram_wen;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_en;
    logic [3:0]  data_sram_wen;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    // program table, row n sits at reset pc + 4n
    string       row_name  [$];
    logic [31:0] row_inst  [$];
    logic        row_wb    [$];
    logic [4:0]  row_wnum  [$];
    logic [31:0] row_wdata [$];

    // SRAM model state
    logic [31:0] dmem [256];
    logic [31:0] inst_next;
    logic [31:0] data_next;
    logic [3:0]  wr_strobe;
    logic [7:0]  wr_index;
    logic [31:0] wr_word;

    // last store seen on the data port
    int          st_count;
    logic [3:0]  st_wen;
    logic [31:0] st_addr;
    logic [31:0] st_data;

    mips_core dut (.*);

    bind mips_core mips_core_properties u_props (
        .clk             (clk),
        .resetn          (resetn),
        .data_sram_wen   (data_sram_wen),
        .debug_wb_pc     (debug_wb_pc),
        .debug_wb_rf_wen (debug_wb_rf_wen)
    );

    always #20 clk = ~clk;

    // --------------------------------------------------
    // encoders and table helpers
    // --------------------------------------------------
    function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [5:0] fn);
        return {`CPU_OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic add_row(input string name, input logic [31:0] inst, input logic wb,
                           input logic [4:0] wnum, input logic [31:0] wdata);
        row_name.push_back(name);
        row_inst.push_back(inst);
        row_wb.push_back(wb);
        row_wnum.push_back(wnum);
        row_wdata.push_back(wdata);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch in %s: expected %h, actual %h",
                                name, expected, actual));
        end
    endtask

    // SRAM enables stay high, instruction side never writes
    task automatic check_tie_offs();
        check_equal("inst sram enable", 32'h1, 32'(inst_sram_en));
        check_equal("inst sram strobe", 32'h0, 32'(inst_sram_wen));
        check_equal("inst sram wdata", 32'h0, inst_sram_wdata);
        check_equal("data sram enable", 32'h1, 32'(data_sram_en));
    endtask

    task automatic load_program();
        // immediates and R-type ops
        add_row("addiu pos", i_type(`CPU_OP_ADDIU, 5'd0, 5'd1, 16'h0005), 1'b1, 5'd1, 32'h5);
        add_row("addiu neg", i_type(`CPU_OP_ADDIU, 5'd0, 5'd2, 16'hfffd), 1'b1, 5'd2,
                32'hfffffffd);
        add_row("ori zext", i_type(`CPU_OP_ORI, 5'd0, 5'd3, 16'h8001), 1'b1, 5'd3, 32'h8001);
        add_row("lui", i_type(`CPU_OP_LUI, 5'd0, 5'd4, 16'h1234), 1'b1, 5'd4, 32'h12340000);
        add_row("addu", r_type(5'd1, 5'd2, 5'd5, `CPU_FN_ADDU), 1'b1, 5'd5, 32'h2);
        add_row("subu wrap", r_type(5'd1, 5'd3, 5'd6, `CPU_FN_SUBU), 1'b1, 5'd6, 32'hffff8004);
        add_row("and", r_type(5'd2, 5'd3, 5'd7, `CPU_FN_AND), 1'b1, 5'd7, 32'h8001);
        add_row("or", r_type(5'd3, 5'd4, 5'd8, `CPU_FN_OR), 1'b1, 5'd8, 32'h12348001);
        add_row("xor", r_type(5'd2, 5'd4, 5'd9, `CPU_FN_XOR), 1'b1, 5'd9, 32'hedcbfffd);
        add_row("slt neg", r_type(5'd2, 5'd1, 5'd10, `CPU_FN_SLT), 1'b1, 5'd10, 32'h1);
        add_row("sltu neg", r_type(5'd2, 5'd1, 5'd11, `CPU_FN_SLTU), 1'b1, 5'd11, 32'h0);
        // back-to-back chain, stall then mem and wb bypass
        add_row("chain addiu", i_type(`CPU_OP_ADDIU, 5'd1, 5'd12, 16'h0001), 1'b1, 5'd12, 32'h6);
        add_row("chain addu", r_type(5'd12, 5'd12, 5'd13, `CPU_FN_ADDU), 1'b1, 5'd13, 32'hc);
        add_row("chain subu", r_type(5'd13, 5'd12, 5'd14, `CPU_FN_SUBU), 1'b1, 5'd14, 32'h6);
        add_row("chain ori", i_type(`CPU_OP_ORI, 5'd14, 5'd15, 16'h00f0), 1'b1, 5'd15, 32'hf6);
        // store, reload, use the load at once
        add_row("base addr", i_type(`CPU_OP_ADDIU, 5'd0, 5'd16, 16'h0100), 1'b1, 5'd16, 32'h100);
        add_row("sw", i_type(`CPU_OP_SW, 5'd16, 5'd9, 16'h0008), 1'b0, 5'd0, 32'h0);
        add_row("lw", i_type(`CPU_OP_LW, 5'd16, 5'd17, 16'h0008), 1'b1, 5'd17, 32'hedcbfffd);
        add_row("load use", r_type(5'd17, 5'd1, 5'd18, `CPU_FN_ADDU), 1'b1, 5'd18, 32'hedcc0002);
        // $0 target is dropped, $0 still reads zero
        add_row("write r0", i_type(`CPU_OP_ADDIU, 5'd1, 5'd0, 16'h0055), 1'b0, 5'd0, 32'h0);
        add_row("read r0", r_type(5'd0, 5'd1, 5'd19, `CPU_FN_ADDU), 1'b1, 5'd19, 32'h5);
    endtask

    // --------------------------------------------------
    // SRAM models, one-cycle read
    // --------------------------------------------------
    // requests sampled mid-cycle, core outputs settled by then
    always @(negedge clk) begin
        int row;
        row = int'((inst_sram_addr - `CPU_RESET_PC) >> 2);
        // nop past the end of the table
        inst_next = (row < row_inst.size()) ? row_inst[row] : 32'h0;
        data_next = dmem[data_sram_addr[9:2]];
        wr_strobe = data_sram_wen;
        wr_index  = data_sram_addr[9:2];
        wr_word   = data_sram_wdata;
        if (resetn && data_sram_wen != 4'h0) begin
            st_count = st_count + 1;
            st_wen   = data_sram_wen;
            st_addr  = data_sram_addr;
            st_data  = data_sram_wdata;
        end
    end

    // answers go out just after the edge
    always @(posedge clk) begin
        #1;
        inst_sram_rdata = inst_next;
        data_sram_rdata = data_next;
        if (wr_strobe == `CPU_SW_STROBE) begin
            dmem[wr_index] = wr_word;
        end
    end

    // --------------------------------------------------
    // reset, then walk the table
    // --------------------------------------------------
    initial begin
        int cycles;
        clk             = 1'b0;
        resetn          = 1'b0;
        inst_sram_rdata = 32'h0;
        data_sram_rdata = 32'h0;
        inst_next       = 32'h0;
        data_next       = 32'h0;
        wr_strobe       = 4'h0;
        wr_index        = 8'h0;
        wr_word         = 32'h0;
        st_count        = 0;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'h0;
        end
        load_program();

        // two cycles of reset
        @(posedge clk);
        @(negedge clk);
        check_equal("reset debug wen", 32'h0, 32'(debug_wb_rf_wen));
        check_equal("reset data wen", 32'h0, 32'(data_sram_wen));
        check_equal("reset fetch address", `CPU_RESET_PC, inst_sram_addr);
        check_tie_offs();
        @(posedge clk);
        #1 resetn = 1'b1;
        @(negedge clk);
        check_equal("first fetch address", `CPU_RESET_PC, inst_sram_addr);

        for (int i = 0; i < row_inst.size(); i++) begin
            if (row_wb[i]) begin
                cycles = 0;
                @(negedge clk);
                while (debug_wb_rf_wen == 4'h0 && cycles < WB_TIMEOUT) begin
                    // nothing stores before the first write
                    if (i == 0) begin
                        check_equal("early data wen", 32'h0, 32'(data_sram_wen));
                    end
                    cycles = cycles + 1;
                    @(negedge clk);
                end
                if (debug_wb_rf_wen == 4'h0) begin
                    abort_run($sformatf("row %0d (%s) never wrote back", i, row_name[i]));
                end
                check_equal({row_name[i], " wen"}, 32'hf, 32'(debug_wb_rf_wen));
                check_equal({row_name[i], " wnum"}, 32'(row_wnum[i]), 32'(debug_wb_rf_wnum));
                check_equal({row_name[i], " wdata"}, row_wdata[i], debug_wb_rf_wdata);
                check_equal({row_name[i], " pc"}, `CPU_RESET_PC + (32'(i) << 2), debug_wb_pc);
            end
        end

        // only nops follow, nothing may write
        repeat (10) begin
            @(negedge clk);
            check_equal("trailing debug wen", 32'h0, 32'(debug_wb_rf_wen));
            check_tie_offs();
        end
        check_equal("store count", 32'd1, 32'(st_count));
        check_equal("store strobe", 32'hf, 32'(st_wen));
        check_equal("store address", 32'h108, st_addr);
        check_equal("store data", 32'hedcbfffd, st_data);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+common
common/cpu_pkg.sv
common/cpu_if.sv
hdl/fetch_stage.sv
decode/reg_file.sv
decode/decode_stage.sv
hdl/exec_stage.sv
hdl/mem_stage.sv
hdl/pipe_control.sv
hdl/mips_core.sv
verification/mips_core_properties.sv
verification/tb_mips_core.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_mips_core -f tb.f -o tb_mips_core \
    && ./obj_dir/tb_mips_core > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "\*\*\* FAILED \*\*\*" sim.log && echo "simulation failed" && exit 1
grep -q "\*\*\* PASSED \*\*\*" sim.log || { echo "simulation did not pass"; exit 1; }
exit 0
